// File: Makefile
# Verilator build and run for the TMU pixel path testbench

VERILATOR ?= verilator
TOP       ?= tb_tmu_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TB FAILED

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log is searched, so a run that ends in failure makes make fail
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src.f
src/tmu_pixel_pkg.sv
src/tmu_cfg_pkg.sv
src/tmu_frame_ctl.sv
src/tmu_dst_scan.sv
src/tmu_decay.sv
src/tmu_fb_write.sv
src/tmu_top.sv
verif/tmu_checker.sv
verif/tb_tmu_top.sv

// File: src/tmu_cfg_pkg.sv
package tmu_cfg_pkg;

	import tmu_pixel_pkg::*;

	//##################################################
	// per-frame setup
	//##################################################

	typedef struct packed {
		logic [5:0] brightness;	// 63 means unscaled
		logic chroma_key_en;	// drop keyed pixels
		pixel_u chroma_key;	// compared as raw word
	} decay_cfg_t;

	// stride equals hres
	typedef struct packed {
		logic [fb_adr_w_max-1:0] dst_base;	// halfword address
		logic [10:0] hres;	// pixels per row
		logic [10:0] vres;	// rows per frame
	} frame_geom_t;

endpackage

// File: src/tmu_decay.sv
`timescale 1ns/1ps

module tmu_decay import tmu_pixel_pkg::*, tmu_cfg_pkg::*; #(
	parameter int fml_depth = 26
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  decay_cfg_t           cfg_i,
	output logic                 busy_o,
	input  logic                 pipe_stb_i,
	output logic                 pipe_ack_o,
	input  pixel_u               src_pixel_i,
	input  logic [fml_depth-2:0] dst_addr_i,
	output logic                 pipe_stb_o,
	input  logic                 pipe_ack_i,
	output pixel_u               src_pixel_o,
	output logic [fml_depth-2:0] dst_addr_o
);

	logic en;
	logic s1_valid;
	logic s2_valid;
	logic s3_valid;
	logic key_hit;

	pixel_u s1_pix;
	pixel_u s2_pix;
	logic [fml_depth-2:0] s1_addr;
	logic [fml_depth-2:0] s2_addr;
	logic [5:0] s1_bright1;	// wraps to 0 at full brightness
	logic s1_full;
	logic s2_full;
	logic [10:0] s2_r;
	logic [11:0] s2_g;
	logic [10:0] s2_b;

	assign en = pipe_ack_i;	// downstream ack moves all stages
	assign pipe_ack_o = pipe_ack_i;
	assign key_hit = cfg_i.chroma_key_en & (s1_pix.raw == cfg_i.chroma_key.raw);

	//##################################################
	// valid chain
	//##################################################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
		end else if (en) begin
			s1_valid <= pipe_stb_i;
			s2_valid <= s1_valid & ~key_hit;	// keyed pixel dies here
			s3_valid <= s2_valid;
		end
	end

	//##################################################
	// data path
	//##################################################

	always_ff @(posedge sys_clk) begin
		if (en) begin
			s1_pix <= src_pixel_i;
			s1_addr <= dst_addr_i;
			s1_bright1 <= cfg_i.brightness + 6'd1;
			s1_full <= cfg_i.brightness == 6'd63;

			s2_pix <= s1_pix;
			s2_addr <= s1_addr;
			s2_full <= s1_full;
			s2_r <= s1_bright1 * s1_pix.rgb.r;	// 11 bit product
			s2_g <= s1_bright1 * s1_pix.rgb.g;	// 12 bit product
			s2_b <= s1_bright1 * s1_pix.rgb.b;

			dst_addr_o <= s2_addr;
			if (s2_full) begin
				src_pixel_o <= s2_pix;	// bypass, multiplier saw zero
			end else begin
				src_pixel_o.rgb.r <= s2_r[10:6];	// divide by 64
				src_pixel_o.rgb.g <= s2_g[11:6];
				src_pixel_o.rgb.b <= s2_b[10:6];
			end
		end
	end

	assign pipe_stb_o = s3_valid;
	assign busy_o = s1_valid | s2_valid | s3_valid;

	a_stb_known: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!$isunknown(pipe_stb_o));

endmodule

// File: src/tmu_dst_scan.sv
`timescale 1ns/1ps

module tmu_dst_scan import tmu_pixel_pkg::*, tmu_cfg_pkg::*; #(
	parameter int fml_depth = 26
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 arm_i,
	input  frame_geom_t          geom_i,
	input  logic                 pix_stb_i,
	input  pixel_u               pix_i,
	output logic                 pix_ack_o,
	output logic                 out_stb_o,
	output pixel_u               out_pix_o,
	output logic [fml_depth-2:0] out_addr_o,
	input  logic                 out_ack_i,
	output logic                 done_o
);

	logic [10:0] x_cnt;
	logic [10:0] y_cnt;
	logic [fml_depth-2:0] row_off;	// y times hres, kept as running sum
	logic ready;
	logic xfer;
	logic last_x;
	logic last_y;

	assign ready = arm_i & ~done_o;	// closed outside a frame
	assign out_stb_o = pix_stb_i & ready;
	assign pix_ack_o = out_ack_i & ready;
	assign out_pix_o = pix_i;	// pixel passes untouched
	assign out_addr_o = geom_i.dst_base[fml_depth-2:0] + row_off + (fml_depth-1)'(x_cnt);

	assign xfer = out_stb_o & out_ack_i;
	assign last_x = x_cnt == geom_i.hres - 11'd1;
	assign last_y = y_cnt == geom_i.vres - 11'd1;

	always_ff @(posedge sys_clk) begin
		if (sys_rst || !arm_i) begin	// rewind between frames
			x_cnt <= '0;
			y_cnt <= '0;
			row_off <= '0;
			done_o <= 1'b0;
		end else if (xfer) begin
			if (last_x) begin
				x_cnt <= '0;
				y_cnt <= y_cnt + 11'd1;
				row_off <= row_off + (fml_depth-1)'(geom_i.hres);	// next row
				if (last_y)
					done_o <= 1'b1;	// frame fully scanned
			end else begin
				x_cnt <= x_cnt + 11'd1;
			end
		end
	end

	a_x_in_row: assert property (@(posedge sys_clk) disable iff (sys_rst)
		arm_i |-> x_cnt < geom_i.hres);

endmodule

// File: src/tmu_fb_write.sv
`timescale 1ns/1ps

module tmu_fb_write import tmu_pixel_pkg::*; #(
	parameter int fml_depth = 26
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 in_stb_i,
	input  pixel_u               in_pix_i,
	input  logic [fml_depth-2:0] in_addr_i,
	output logic                 in_ack_o,
	input  logic                 flush_i,
	output logic                 idle_o,
	output logic                 fb_stb_o,
	output fb_wr_t               fb_o,
	input  logic                 fb_ack_i
);

	logic pend_v;	// even halfword waiting for its partner
	pixel_u pend_pix;
	logic [fml_depth-2:0] pend_adr;
	logic wr_v;	// write outstanding on fb port
	fb_wr_t wr_q;
	logic flush_req;	// flush seen while a halfword still waits
	logic pair;
	logic take;
	logic hold_even;
	logic odd_solo;
	logic pend_issue;
	logic wr_load;

	assign pair = pend_v & in_stb_i & (in_addr_i == {pend_adr[fml_depth-2:1], 1'b1});
	// a non-partner waits while the pending halfword goes out alone
	assign in_ack_o = ~wr_v & (~pend_v | pair | ~in_stb_i);
	assign take = in_stb_i & in_ack_o;
	assign hold_even = take & ~pend_v & ~in_addr_i[0];
	assign odd_solo = take & ~pend_v & in_addr_i[0];
	assign pend_issue = ~wr_v & pend_v & ~pair & (in_stb_i | flush_req);
	assign wr_load = (take & pair) | odd_solo | pend_issue;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pend_v <= 1'b0;
			wr_v <= 1'b0;
			flush_req <= 1'b0;
		end else begin
			if (wr_load)
				wr_v <= 1'b1;
			else if (fb_ack_i)
				wr_v <= 1'b0;	// write accepted
			if (hold_even)
				pend_v <= 1'b1;
			else if ((take & pair) | pend_issue)
				pend_v <= 1'b0;
			flush_req <= flush_i | (flush_req & pend_v & ~pend_issue);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (hold_even) begin
			pend_pix <= in_pix_i;
			pend_adr <= in_addr_i;
		end
		if (take & pair) begin	// both lanes
			wr_q.adr <= fb_adr_w_max'(pend_adr[fml_depth-2:1]);
			wr_q.dat <= {in_pix_i.raw, pend_pix.raw};
			wr_q.sel <= 2'b11;
		end else if (pend_issue) begin	// even lane only
			wr_q.adr <= fb_adr_w_max'(pend_adr[fml_depth-2:1]);
			wr_q.dat <= {16'h0000, pend_pix.raw};
			wr_q.sel <= 2'b01;
		end else if (odd_solo) begin	// odd lane only
			wr_q.adr <= fb_adr_w_max'(in_addr_i[fml_depth-2:1]);
			wr_q.dat <= {in_pix_i.raw, 16'h0000};
			wr_q.sel <= 2'b10;
		end
	end

	assign fb_stb_o = wr_v;
	assign fb_o = wr_q;
	assign idle_o = ~pend_v & ~wr_v;

	a_sel_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fb_stb_o |-> fb_o.sel != 2'b00);

endmodule

// File: src/tmu_frame_ctl.sv
`timescale 1ns/1ps

module tmu_frame_ctl import tmu_cfg_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic        start_i,
	input  decay_cfg_t  cfg_i,
	input  frame_geom_t geom_i,
	input  logic        scan_done_i,
	input  logic        decay_busy_i,
	input  logic        wr_idle_i,
	output decay_cfg_t  cfg_o,
	output frame_geom_t geom_o,
	output logic        arm_o,
	output logic        flush_o,
	output logic        busy_o,
	output logic        done_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_flush,
		st_done
	} state_t;

	state_t state;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= st_idle;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;	// single cycle pulse
			case (state)
				st_idle: begin
					if (start_i)
						state <= st_run;
				end
				st_run: begin
					if (scan_done_i && !decay_busy_i)	// all pixels through decay
						state <= st_flush;
				end
				st_flush: begin
					state <= st_done;	// one flush cycle
				end
				default: begin
					if (wr_idle_i) begin	// last write acked
						state <= st_idle;
						done_o <= 1'b1;
					end
				end
			endcase
		end
	end

	// frame setup held for the whole frame
	always_ff @(posedge sys_clk) begin
		if (start_i && state == st_idle) begin
			cfg_o <= cfg_i;
			geom_o <= geom_i;
		end
	end

	assign arm_o = state == st_run;	// scan accepts pixels
	assign flush_o = state == st_flush;
	assign busy_o = state != st_idle;

	a_no_start_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
		start_i |-> !busy_o);

endmodule

// File: src/tmu_pixel_pkg.sv
package tmu_pixel_pkg;

	//##################################################
	// pixel formats
	//##################################################

	localparam int fb_adr_w_max = 30;	// widest word address on the fb port

	typedef struct packed {
		logic [4:0] r;	// red in the top bits
		logic [5:0] g;	// green, six bits wide
		logic [4:0] b;	// blue in the bottom bits
	} rgb565_t;

	// raw view for keying, field view for scaling
	typedef union packed {
		logic [15:0] raw;	// whole halfword
		rgb565_t rgb;	// split channels
	} pixel_u;

	//##################################################
	// framebuffer write word
	//##################################################

	typedef struct packed {
		logic [fb_adr_w_max-1:0] adr;	// word address, upper bits zero
		logic [31:0] dat;	// even halfword sits low
		logic [1:0] sel;	// bit 0 picks the low lane
	} fb_wr_t;

endpackage

// File: src/tmu_top.sv
`timescale 1ns/1ps

module tmu_top import tmu_pixel_pkg::*, tmu_cfg_pkg::*; #(
	parameter int fml_depth = 26
) (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic        start_i,
	input  decay_cfg_t  cfg_i,
	input  frame_geom_t geom_i,
	input  logic        pix_stb_i,
	input  pixel_u      pix_i,
	output logic        pix_ack_o,
	output logic        fb_stb_o,
	output fb_wr_t      fb_o,
	input  logic        fb_ack_i,
	output logic        busy_o,
	output logic        done_o
);

	decay_cfg_t cfg_q;	// frame-stable copies
	frame_geom_t geom_q;
	logic arm;
	logic flush;
	logic scan_done;
	logic decay_busy;
	logic wr_idle;

	//##################################################
	// scan to decay to writer
	//##################################################

	logic scan_stb;
	logic scan_ack;
	pixel_u scan_pix;
	logic [fml_depth-2:0] scan_addr;
	logic dec_stb;
	logic dec_ack;
	pixel_u dec_pix;
	logic [fml_depth-2:0] dec_addr;

	tmu_frame_ctl u_frame_ctl (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.start_i      (start_i),
		.cfg_i        (cfg_i),
		.geom_i       (geom_i),
		.scan_done_i  (scan_done),
		.decay_busy_i (decay_busy),
		.wr_idle_i    (wr_idle),
		.cfg_o        (cfg_q),
		.geom_o       (geom_q),
		.arm_o        (arm),
		.flush_o      (flush),
		.busy_o       (busy_o),
		.done_o       (done_o)
	);

	tmu_dst_scan #(.fml_depth(fml_depth)) u_dst_scan (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.arm_i      (arm),
		.geom_i     (geom_q),
		.pix_stb_i  (pix_stb_i),
		.pix_i      (pix_i),
		.pix_ack_o  (pix_ack_o),
		.out_stb_o  (scan_stb),
		.out_pix_o  (scan_pix),
		.out_addr_o (scan_addr),
		.out_ack_i  (scan_ack),
		.done_o     (scan_done)
	);

	tmu_decay #(.fml_depth(fml_depth)) u_decay (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.cfg_i       (cfg_q),
		.busy_o      (decay_busy),
		.pipe_stb_i  (scan_stb),
		.pipe_ack_o  (scan_ack),	// writer ack passed straight back
		.src_pixel_i (scan_pix),
		.dst_addr_i  (scan_addr),
		.pipe_stb_o  (dec_stb),
		.pipe_ack_i  (dec_ack),
		.src_pixel_o (dec_pix),
		.dst_addr_o  (dec_addr)
	);

	tmu_fb_write #(.fml_depth(fml_depth)) u_fb_write (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.in_stb_i  (dec_stb),
		.in_pix_i  (dec_pix),
		.in_addr_i (dec_addr),
		.in_ack_o  (dec_ack),
		.flush_i   (flush),
		.idle_o    (wr_idle),
		.fb_stb_o  (fb_stb_o),
		.fb_o      (fb_o),
		.fb_ack_i  (fb_ack_i)
	);

endmodule

// File: verif/tb_tmu_top.sv
`timescale 1ns/1ps

module tb_tmu_top import tmu_pixel_pkg::*, tmu_cfg_pkg::*;;

	localparam int fml_depth = 26;
	localparam string case_file = "verif/tmu_cases.txt";

	logic sys_clk = 1'b0;
	logic sys_rst;
	logic start;
	decay_cfg_t cfg;
	frame_geom_t geom;
	logic pix_stb;
	pixel_u pix;
	logic pix_ack;
	logic fb_stb;
	fb_wr_t fb;
	logic fb_ack;
	logic busy;
	logic done;
	int err_cnt;
	int wr_cnt;

	decay_cfg_t case_cfg[$];	// one entry per line of the case file
	frame_geom_t case_geom[$];
	int case_mode[$];
	integer seed;
	int cyc_cnt = 0;
	int cyc_limit = 0;
	int n_fail;

	tmu_top #(.fml_depth(fml_depth)) UUT (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .start_i(start), .cfg_i(cfg), .geom_i(geom),
		.pix_stb_i(pix_stb), .pix_i(pix), .pix_ack_o(pix_ack), .fb_stb_o(fb_stb), .fb_o(fb),
		.fb_ack_i(fb_ack), .busy_o(busy), .done_o(done)
	);

	tmu_checker #(.fml_depth(fml_depth)) u_checker (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .start_i(start), .cfg_i(cfg), .geom_i(geom),
		.pix_stb_i(pix_stb), .pix_i(pix), .pix_ack_i(pix_ack), .fb_stb_i(fb_stb), .fb_i(fb),
		.fb_ack_i(fb_ack), .busy_i(busy), .done_i(done), .err_cnt_o(err_cnt), .wr_cnt_o(wr_cnt)
	);

	initial begin
		forever #10 sys_clk = ~sys_clk;	// 20 ns period
	end

	always @(negedge sys_clk) begin
		fb_ack = !sys_rst && (($random(seed) & 3) != 0);	// withheld one time in four
	end

	always @(posedge sys_clk) begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt > cyc_limit + 8) begin
			$display("timeout, no end of run after %0d cycles", cyc_cnt);
			$display("TB FAILED");
			$finish;
		end
	end

	//##################################################
	// stimulus
	//##################################################

	task automatic load_cases();
		int fd;
		string line;
		int bright, key_en, key, base, hres, vres, mode;
		decay_cfg_t c;
		frame_geom_t g;
		fd = $fopen(case_file, "r");
		if (fd == 0) begin
			$display("cannot open the case file %s", case_file);
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if ($sscanf(line, "%d %d %h %h %d %d %d", bright, key_en, key, base, hres, vres,
				mode) == 7) begin	// comment lines fail the scan
				c.brightness = 6'(bright);
				c.chroma_key_en = key_en[0];
				c.chroma_key.raw = 16'(key);
				g.dst_base = fb_adr_w_max'(base);
				g.hres = 11'(hres);
				g.vres = 11'(vres);
				case_cfg.push_back(c);
				case_geom.push_back(g);
				case_mode.push_back(mode);
				cyc_limit += 4 * (hres * vres + 8);
			end
		end
		$fclose(fd);
	endtask

	task automatic make_pixel(input int mode, input pixel_u key);
		if (mode == 1 && ($random(seed) & 1))
			pix = key;	// key-heavy stream
		else
			pix.raw = 16'($random(seed));
	endtask

	task automatic send_frame(input int n, input int mode, input pixel_u key);
		for (int i = 0; i < n; i++) begin
			if (i > 0)
				make_pixel(mode, key);	// first pixel already on offer
			pix_stb = 1'b1;
			@(posedge sys_clk);
			while (!pix_ack)
				@(posedge sys_clk);
			@(negedge sys_clk);
		end
		pix_stb = 1'b0;
	endtask

	task automatic run_case(input int idx);
		int n;
		int errs;
		int writes;
		errs = err_cnt;
		writes = wr_cnt;
		n = int'(case_geom[idx].hres) * int'(case_geom[idx].vres);
		cfg = case_cfg[idx];
		geom = case_geom[idx];
		make_pixel(case_mode[idx], case_cfg[idx].chroma_key);
		pix_stb = 1'b1;	// offered ahead of start, no ack yet
		@(negedge sys_clk);
		start = 1'b1;
		@(negedge sys_clk);
		start = 1'b0;
		send_frame(n, case_mode[idx], case_cfg[idx].chroma_key);
		@(posedge sys_clk);
		while (!done)	// frame drained
			@(posedge sys_clk);
		@(negedge sys_clk);
		if (err_cnt == errs) begin
			$display("test %0d ok, %0d pixels, %0d writes", idx, n, wr_cnt - writes);
		end else begin
			n_fail++;
			$display("test %0d failed with %0d errors", idx, err_cnt - errs);
		end
	endtask

	initial begin
		sys_rst = 1'b1;
		start = 1'b0;
		cfg = '0;
		geom = '0;
		pix_stb = 1'b0;
		pix = '0;
		fb_ack = 1'b0;
		seed = 32'h0c17_fb22;
		n_fail = 0;
		load_cases();
		repeat (2) @(negedge sys_clk);
		sys_rst = 1'b0;
		if (case_cfg.size() == 0)
			$display("no test cases were read from %s", case_file);
		for (int i = 0; i < case_cfg.size(); i++)
			run_case(i);
		$display("%0d tests, %0d failed, %0d errors, %0d writes", case_cfg.size(), n_fail,
			err_cnt, wr_cnt);
		if (err_cnt == 0 && n_fail == 0 && case_cfg.size() > 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: verif/tmu_cases.txt
# brightness key_en key(hex) base(hex) hres vres mode
# mode 0 random pixels, mode 1 about half of the pixels equal the key
63 0 0000 000100 8 4 0
40 0 0000 000200 6 3 0
0 0 0000 000040 5 2 0
63 1 f81f 000301 7 3 1
17 1 07e0 000455 9 5 1
63 0 f81f 000011 3 3 1
31 1 001f 000600 1 6 0
52 1 ffff 000723 11 4 1

// File: verif/tmu_checker.sv
`timescale 1ns/1ps

module tmu_checker import tmu_pixel_pkg::*, tmu_cfg_pkg::*; #(
	parameter int fml_depth = 26
) (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic        start_i,
	input  decay_cfg_t  cfg_i,
	input  frame_geom_t geom_i,
	input  logic        pix_stb_i,
	input  pixel_u      pix_i,
	input  logic        pix_ack_i,
	input  logic        fb_stb_i,
	input  fb_wr_t      fb_i,
	input  logic        fb_ack_i,
	input  logic        busy_i,
	input  logic        done_i,
	output int          err_cnt_o,
	output int          wr_cnt_o
);

	localparam logic [31:0] hw_mask = (32'd1 << (fml_depth-1)) - 32'd1;	// halfword space
	localparam logic [31:0] adr_mask = (32'd1 << (fml_depth-2)) - 32'd1;	// word space

	decay_cfg_t cfg_q;	// setup seen at start
	frame_geom_t geom_q;
	fb_wr_t exp_q[$];	// predicted writes in order
	logic frame_act;
	int x;
	int y;
	int pix_cnt;
	int total;
	logic pend_v;	// model of the even halfword held back
	logic [31:0] pend_adr;
	logic [15:0] pend_pix;

	//##################################################
	// reference rules
	//##################################################

	function automatic logic [15:0] scale_pixel(input pixel_u p, input logic [5:0] bright);
		rgb565_t c;
		int f;
		f = int'(bright) + 1;
		c = p.rgb;
		if (bright != 6'd63) begin	// 63 is pass-through
			c.r = 5'((f * int'(c.r)) >> 6);
			c.g = 6'((f * int'(c.g)) >> 6);
			c.b = 5'((f * int'(c.b)) >> 6);
		end
		return c;
	endfunction

	function automatic fb_wr_t make_wr(input logic [31:0] hw_adr, input logic [31:0] dat,
		input logic [1:0] sel);
		fb_wr_t w;
		w = '0;
		w.adr = fb_adr_w_max'(hw_adr >> 1);	// halfword to word
		w.dat = dat;
		w.sel = sel;
		return w;
	endfunction

	task automatic merge_pixel(input logic [31:0] adr, input logic [15:0] pix);
		if (pend_v && adr == pend_adr + 32'd1) begin	// partner found
			exp_q.push_back(make_wr(pend_adr, {pix, pend_pix}, 2'b11));
			pend_v = 1'b0;
		end else begin
			if (pend_v)
				exp_q.push_back(make_wr(pend_adr, {16'h0000, pend_pix}, 2'b01));
			pend_v = 1'b0;
			if (adr[0]) begin
				exp_q.push_back(make_wr(adr, {pix, 16'h0000}, 2'b10));	// odd alone
			end else begin
				pend_v = 1'b1;
				pend_adr = adr;
				pend_pix = pix;
			end
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt_o++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	//##################################################
	// port watch
	//##################################################

	always @(posedge sys_clk) begin : watch
		fb_wr_t exp_w;
		logic [31:0] adr;
		if (sys_rst) begin
			frame_act = 1'b0;
			pend_v = 1'b0;
			exp_q.delete();
			err_cnt_o = 0;
			wr_cnt_o = 0;
		end else begin
			// high from the cycle after start until done
			compare_value("busy_o", 32'(busy_i), 32'(frame_act && !done_i));
			if (start_i) begin	// new frame
				cfg_q = cfg_i;
				geom_q = geom_i;
				frame_act = 1'b1;
				x = 0;
				y = 0;
				pix_cnt = 0;
				pend_v = 1'b0;
				total = int'(geom_i.hres) * int'(geom_i.vres);
			end
			if (pix_stb_i && pix_ack_i) begin
				if (!frame_act || pix_cnt >= total) begin
					err_cnt_o++;
					$display("a pixel was accepted outside of a frame");
				end
				adr = (32'(geom_q.dst_base) + 32'(y * int'(geom_q.hres) + x)) & hw_mask;
				if (!(cfg_q.chroma_key_en && pix_i.raw == cfg_q.chroma_key.raw))
					merge_pixel(adr, scale_pixel(pix_i, cfg_q.brightness));
				x++;
				if (x == int'(geom_q.hres)) begin	// row wrap
					x = 0;
					y++;
				end
				pix_cnt++;
				if (pix_cnt == total && pend_v) begin	// end of frame flush
					exp_q.push_back(make_wr(pend_adr, {16'h0000, pend_pix}, 2'b01));
					pend_v = 1'b0;
				end
			end
			if (fb_stb_i && fb_ack_i) begin
				wr_cnt_o++;
				if (exp_q.size() == 0) begin
					err_cnt_o++;
					$display("unexpected framebuffer write to word address %h", fb_i.adr);
				end else begin
					exp_w = exp_q.pop_front();
					compare_value("fb_o.adr", 32'(fb_i.adr) & adr_mask,
						32'(exp_w.adr) & adr_mask);
					compare_value("fb_o.sel", 32'(fb_i.sel), 32'(exp_w.sel));
					if (exp_w.sel[0])	// only lanes in use
						compare_value("fb_o.dat[15:0]", 32'(fb_i.dat[15:0]),
							32'(exp_w.dat[15:0]));
					if (exp_w.sel[1])
						compare_value("fb_o.dat[31:16]", 32'(fb_i.dat[31:16]),
							32'(exp_w.dat[31:16]));
				end
			end
			if (done_i) begin
				if (!frame_act) begin
					err_cnt_o++;
					$display("done_o pulsed while no frame was running");
				end
				if (exp_q.size() != 0) begin
					err_cnt_o++;
					$display("%0d expected framebuffer writes never happened", exp_q.size());
				end
				if (pix_cnt != total) begin
					err_cnt_o++;
					$display("frame ended after %0d of %0d pixels", pix_cnt, total);
				end
				exp_q.delete();
				frame_act = 1'b0;
			end
		end
	end

endmodule
